// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_usb_desc
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/usb_desc_params.svh ====
`ifndef USB_DESC_PARAMS_SVH
`define USB_DESC_PARAMS_SVH

// device identity, little-endian in the device descriptor
`define USB_VENDOR_ID          16'h1234
`define USB_PRODUCT_ID         16'h5678
`define USB_VERSION_BCD        16'h0100

// string descriptors 1 and 2, leftmost character is sent first
`define USB_VENDOR_STR         "Sample Vendor"
`define USB_VENDOR_STR_LEN     13
`define USB_PRODUCT_STR        "UVC Test Camera"
`define USB_PRODUCT_STR_LEN    15

`define USB_HS_SUPPORT         1'b0          // picks bcdUSB 2.00 over 1.10
`define USB_SELF_POWERED       1'b0          // bmAttributes bit 6

// endpoints, the IN bit is added in the config table
`define UVC_STATUS_EP_NUM      4'd2          // interrupt status endpoint
`define UVC_DATA_EP_NUM        4'd1          // isochronous video endpoint

// uncompressed YUY2 stream, 640x480 at 30 fps
`define UVC_WIDTH              16'd640
`define UVC_HEIGHT             16'd480
`define UVC_MIN_BIT_RATE       32'd147456000 // w * h * 16 * 30
`define UVC_MAX_BIT_RATE       32'd147456000
`define UVC_MAX_FRAME_SIZE     32'd614400    // w * h * 2
`define UVC_FRAME_INTERVAL     32'd333333    // 100 ns units
`define UVC_BITS_PER_PIXEL     8'd16
`define UVC_PACKET_SIZE        11'd1023      // full-speed iso maximum
`define UVC_ADDITIONAL_PACKET  2'd0          // no extra transactions per microframe

`endif

// ==== logic/desc_addr_map.sv ====
`timescale 1ns/1ps

module desc_addr_map (
    desc_lookup_if.mapper             lk,
    input  usb_desc_pkg::desc_kind_e  i_desc_kind,
    output usb_desc_pkg::desc_addr_t  o_desc_addr,
    output usb_desc_pkg::desc_len_t   o_desc_len
);
    import usb_desc_pkg::*;

    // address decode, regions in ascending address order
    always_comb begin
        lk.region = REGION_NONE;
        lk.offset = '0;
        if (lk.addr < CFG_ADDR) begin
            lk.region = REGION_STD;              // device, qualifier and padding
            lk.offset = lk.addr;
        end else if (lk.addr < LANG_ADDR) begin
            lk.region = REGION_CFG;
            lk.offset = lk.addr - CFG_ADDR;
        end else if (lk.addr < VENDOR_ADDR) begin
            lk.region = REGION_STD;              // lang string lives in the std table
            lk.offset = lk.addr - LANG_ADDR + LANG_OFS;
        end else if (lk.addr < END_ADDR) begin
            lk.region = REGION_STR;              // vendor then product
            lk.offset = lk.addr - VENDOR_ADDR;
        end
    end

    always_comb begin
        case (lk.region)
            REGION_STD: lk.data = lk.std_byte;
            REGION_CFG: lk.data = lk.cfg_byte;
            REGION_STR: lk.data = lk.str_byte;
            default:    lk.data = '0;            // past END_ADDR
        endcase
    end

    // kind lookup for the device core, same layout table
    always_comb begin
        case (i_desc_kind)
            KIND_DEVICE:    begin o_desc_addr = DEV_ADDR;     o_desc_len = DEV_LEN;     end
            KIND_QUALIFIER: begin o_desc_addr = QUAL_ADDR;    o_desc_len = QUAL_LEN;    end
            KIND_CONFIG:    begin o_desc_addr = CFG_ADDR;     o_desc_len = CFG_LEN;     end
            KIND_LANG:      begin o_desc_addr = LANG_ADDR;    o_desc_len = LANG_LEN;    end
            KIND_VENDOR:    begin o_desc_addr = VENDOR_ADDR;  o_desc_len = VENDOR_LEN;  end
            KIND_PRODUCT:   begin o_desc_addr = PRODUCT_ADDR; o_desc_len = PRODUCT_LEN; end
            default:        begin o_desc_addr = '0;           o_desc_len = '0;          end
        endcase
    end

endmodule

// ==== logic/desc_lookup_if.sv ====
`timescale 1ns/1ps

interface desc_lookup_if;
    import usb_desc_pkg::*;

    desc_addr_t   addr;                      // byte address from the bus slave
    desc_region_e region;                    // decoded ROM region
    desc_addr_t   offset;                    // byte offset inside that region
    desc_byte_t   std_byte;                  // device, qualifier and lang table
    desc_byte_t   cfg_byte;                  // UVC configuration table
    desc_byte_t   str_byte;                  // vendor and product strings
    desc_byte_t   data;                      // selected byte back to the slave

    modport requester (output addr, input data);
    modport mapper (input addr, std_byte, cfg_byte, str_byte, output region, offset, data);
    modport std_rom (input region, offset, output std_byte);
    modport cfg_rom (input offset, output cfg_byte);
    modport str_rom (input offset, output str_byte);

endinterface

// ==== logic/desc_wb_slave.sv ====
`timescale 1ns/1ps

module desc_wb_slave (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  usb_desc_pkg::desc_addr_t  i_wb_adr,
    output usb_desc_pkg::desc_byte_t  o_wb_dat,
    output logic                      o_wb_ack,
    desc_lookup_if.requester          lk
);

    logic req;                                   // request taken at this edge

    assign lk.addr = i_wb_adr;                   // ROM path is combinational
    // no new request while ack is up, so a held stb is served every second cycle
    assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
        end else begin
            o_wb_ack <= req;                     // single-cycle pulse
            if (req) begin
                o_wb_dat <= i_wb_we ? '0 : lk.data; // writes are acked, read back zero
            end
        end
    end

endmodule

// ==== logic/std_desc_rom.sv ====
`timescale 1ns/1ps
`include "usb_desc_params.svh"

module std_desc_rom (
    desc_lookup_if.std_rom lk
);
    import usb_desc_pkg::*;

    localparam logic [15:0] BCD_USB = `USB_HS_SUPPORT ? 16'h0200 : 16'h0110;

    localparam blob_t DEV_DESC = blob_t'({
        DEV_LEN, DT_DEVICE, le16(BCD_USB),
        8'hEF, 8'h02, 8'h01,                     // misc class, common, IAD protocol
        8'h40,                                   // ep0 max packet 64
        le16(`USB_VENDOR_ID), le16(`USB_PRODUCT_ID), le16(`USB_VERSION_BCD),
        8'h01, 8'h02, 8'h00,                     // vendor, product, no serial
        8'h01                                    // one configuration
    });

    localparam blob_t QUAL_DESC = blob_t'({
        QUAL_LEN, DT_QUALIFIER, le16(16'h0200),
        8'hEF, 8'h02, 8'h01, 8'h40,
        8'h01, 8'h00                             // other-speed configs, reserved
    });

    localparam blob_t LANG_DESC = blob_t'({LANG_LEN, DT_STRING, le16(16'h0409)}); // en-US

    int ofs;

    assign ofs = int'(lk.offset);

    always_comb begin
        lk.std_byte = '0;                        // padding 18..19 and 30..31
        if (lk.region == REGION_STD) begin
            case (ofs) inside
                [0:17]:  lk.std_byte = byte_at(DEV_DESC, 18, ofs);
                [20:29]: lk.std_byte = byte_at(QUAL_DESC, 10, ofs - 20);
                [32:35]: lk.std_byte = byte_at(LANG_DESC, 4, ofs - 32);
                default: lk.std_byte = '0;
            endcase
        end
    end

endmodule

// ==== logic/string_desc_rom.sv ====
`timescale 1ns/1ps
`include "usb_desc_params.svh"

module string_desc_rom (
    desc_lookup_if.str_rom lk
);
    import usb_desc_pkg::*;

    localparam blob_t VENDOR_TEXT  = blob_t'(`USB_VENDOR_STR);  // right-aligned chars
    localparam blob_t PRODUCT_TEXT = blob_t'(`USB_PRODUCT_STR);

    logic      is_vendor;                        // vendor string comes first
    int        pos;                              // offset inside the selected string
    int        chars;                            // its character count
    int        idx;                              // character index for a low byte
    desc_len_t len;                              // bLength of the selected string
    blob_t     text;

    assign is_vendor = lk.offset < 10'(VENDOR_LEN);
    assign pos       = is_vendor ? int'(lk.offset) : int'(lk.offset) - int'(VENDOR_LEN);
    assign chars     = is_vendor ? `USB_VENDOR_STR_LEN : `USB_PRODUCT_STR_LEN;
    assign len       = is_vendor ? VENDOR_LEN : PRODUCT_LEN;
    assign text      = is_vendor ? VENDOR_TEXT : PRODUCT_TEXT;
    assign idx       = (pos - 2) / 2;

    // UTF-16LE body, ASCII low byte then zero high byte
    always_comb begin
        if (pos == 0) begin
            lk.str_byte = len;
        end else if (pos == 1) begin
            lk.str_byte = DT_STRING;
        end else if (pos[0] || idx >= chars) begin
            lk.str_byte = '0;                    // high byte or past the end
        end else begin
            lk.str_byte = byte_at(text, chars, idx);
        end
    end

endmodule

// ==== logic/usb_desc_pkg.sv ====
package usb_desc_pkg;

    `include "usb_desc_params.svh"

    typedef logic [7:0] desc_byte_t;         // one ROM byte
    typedef logic [9:0] desc_addr_t;         // ROM byte address
    typedef logic [7:0] desc_len_t;          // descriptor length

    typedef enum logic [2:0] {
        KIND_DEVICE, KIND_QUALIFIER, KIND_CONFIG, KIND_LANG, KIND_VENDOR, KIND_PRODUCT
    } desc_kind_e;

    typedef enum logic [1:0] {
        REGION_STD, REGION_CFG, REGION_STR, REGION_NONE
    } desc_region_e;

    localparam int BLOB_BYTES = 126;                      // longest string descriptor body
    typedef logic [8*BLOB_BYTES-1:0] blob_t;              // byte table, byte 0 leftmost

    // ROM layout, 18..19 and 30..31 are padding
    localparam desc_addr_t DEV_ADDR     = 10'd0;
    localparam desc_len_t  DEV_LEN      = 8'd18;
    localparam desc_addr_t QUAL_ADDR    = 10'd20;
    localparam desc_len_t  QUAL_LEN     = 8'd10;
    localparam desc_addr_t CFG_ADDR     = 10'd32;
    localparam desc_len_t  CFG_LEN      = 8'd174;
    localparam desc_addr_t LANG_ADDR    = CFG_ADDR + 10'(CFG_LEN);
    localparam desc_len_t  LANG_LEN     = 8'd4;
    localparam desc_addr_t VENDOR_ADDR  = LANG_ADDR + 10'(LANG_LEN);
    localparam desc_len_t  VENDOR_LEN   = 8'(2 + 2 * `USB_VENDOR_STR_LEN);
    localparam desc_addr_t PRODUCT_ADDR = VENDOR_ADDR + 10'(VENDOR_LEN);
    localparam desc_len_t  PRODUCT_LEN  = 8'(2 + 2 * `USB_PRODUCT_STR_LEN);
    localparam desc_addr_t END_ADDR     = PRODUCT_ADDR + 10'(PRODUCT_LEN);
    localparam desc_addr_t LANG_OFS     = 10'd32; // lang string sits past the padded qualifier

    // bDescriptorType codes
    localparam desc_byte_t DT_DEVICE       = 8'd1;
    localparam desc_byte_t DT_CONFIG       = 8'd2;
    localparam desc_byte_t DT_STRING       = 8'd3;
    localparam desc_byte_t DT_INTERFACE    = 8'd4;
    localparam desc_byte_t DT_ENDPOINT     = 8'd5;
    localparam desc_byte_t DT_QUALIFIER    = 8'd6;
    localparam desc_byte_t DT_IAD          = 8'd11;
    localparam desc_byte_t DT_CS_INTERFACE = 8'd36;
    localparam desc_byte_t DT_CS_ENDPOINT  = 8'd37;

    function automatic logic [15:0] le16(input logic [15:0] v);
        return {v[7:0], v[15:8]};                         // USB words go low byte first
    endfunction

    function automatic logic [31:0] le32(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    // byte idx of a table that is len bytes long, caller keeps idx < len
    function automatic desc_byte_t byte_at(input blob_t blob, input int len, input int idx);
        return blob[(len - 1 - idx)*8 +: 8];
    endfunction

endpackage

// ==== logic/usb_desc_top.sv ====
`timescale 1ns/1ps

module usb_desc_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  usb_desc_pkg::desc_addr_t  i_wb_adr,
    output usb_desc_pkg::desc_byte_t  o_wb_dat,
    output logic                      o_wb_ack,
    input  usb_desc_pkg::desc_kind_e  i_desc_kind,  // kind lookup, combinational
    output usb_desc_pkg::desc_addr_t  o_desc_addr,
    output usb_desc_pkg::desc_len_t   o_desc_len
);

    desc_lookup_if lk ();                        // address out, byte back

    desc_wb_slave u_wb_slave (
        .CLK      (CLK),
        .RESET    (RESET),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .lk       (lk)
    );

    desc_addr_map u_addr_map (
        .lk          (lk),
        .i_desc_kind (i_desc_kind),
        .o_desc_addr (o_desc_addr),
        .o_desc_len  (o_desc_len)
    );

    std_desc_rom    u_std_rom (.lk(lk)); // device, qualifier, languages
    uvc_cfg_rom     u_cfg_rom (.lk(lk)); // 174-byte configuration
    string_desc_rom u_str_rom (.lk(lk)); // vendor and product strings

endmodule

// ==== logic/uvc_cfg_rom.sv ====
`timescale 1ns/1ps
`include "usb_desc_params.svh"

module uvc_cfg_rom (
    desc_lookup_if.cfg_rom lk
);
    import usb_desc_pkg::*;

    localparam desc_byte_t BM_ATTR = `USB_SELF_POWERED ? 8'hC0 : 8'h80;
    localparam desc_byte_t STAT_EP = {4'h8, `UVC_STATUS_EP_NUM}; // IN endpoint
    localparam desc_byte_t DATA_EP = {4'h8, `UVC_DATA_EP_NUM};

    localparam blob_t CFG_HDR = blob_t'({
        8'h09, DT_CONFIG, le16({8'h00, CFG_LEN}),
        8'h02, 8'h01, 8'h00, BM_ATTR, 8'hFA      // 2 ifaces, config 1, 500 mA
    });
    localparam blob_t IAD = blob_t'({
        8'h08, DT_IAD, 8'h00, 8'h02, 8'h0E, 8'h03, 8'h00, 8'h02 // video collection
    });
    localparam blob_t VC_IF = blob_t'({
        8'h09, DT_INTERFACE, 8'h00, 8'h00, 8'h01, 8'h0E, 8'h01, 8'h00, 8'h02
    });
    localparam blob_t VC_HDR = blob_t'({
        8'h0D, DT_CS_INTERFACE, 8'h01, le16(16'h0110),
        le16(16'd40),                            // VC block up to output terminal
        le32(32'd60000000),                      // clock 60 MHz
        8'h01, 8'h01                             // one streaming iface, number 1
    });
    localparam blob_t IN_TERM = blob_t'({
        8'h12, DT_CS_INTERFACE, 8'h02, 8'h01, le16(16'h0201), // camera terminal 1
        8'h00, 8'h00, 48'h0,                     // no zoom
        8'h03, 24'h0                             // no controls
    });
    localparam blob_t OUT_TERM = blob_t'({
        8'h09, DT_CS_INTERFACE, 8'h03, 8'h02, le16(16'h0101), 8'h00, 8'h01, 8'h00
    });
    localparam blob_t INT_EP = blob_t'({
        8'h07, DT_ENDPOINT, STAT_EP, 8'h03, le16(16'd64), 8'h09
    });
    localparam blob_t CS_INT_EP = blob_t'({8'h05, DT_CS_ENDPOINT, 8'h03, le16(16'd64)});
    localparam blob_t VS_ALT0 = blob_t'({
        8'h09, DT_INTERFACE, 8'h01, 8'h00, 8'h00, 8'h0E, 8'h02, 8'h00, 8'h00 // zero bw
    });
    localparam blob_t VS_IN_HDR = blob_t'({
        8'h0E, DT_CS_INTERFACE, 8'h01, 8'h01,
        le16(16'd71),                            // header, format and frame
        DATA_EP, 8'h00, 8'h02, 8'h01, 8'h00, 8'h00, 8'h01, 8'h00
    });
    localparam blob_t FORMAT = blob_t'({
        8'h1B, DT_CS_INTERFACE, 8'h04, 8'h01, 8'h01,
        128'h5955_5932_0000_1000_8000_00AA_0038_9B71, // YUY2 guid
        `UVC_BITS_PER_PIXEL, 8'h01, 8'h00, 8'h00, 8'h00, 8'h00
    });
    localparam blob_t FRAME = blob_t'({
        8'h1E, DT_CS_INTERFACE, 8'h05, 8'h01, 8'h01,
        le16(`UVC_WIDTH), le16(`UVC_HEIGHT),
        le32(`UVC_MIN_BIT_RATE), le32(`UVC_MAX_BIT_RATE),
        le32(`UVC_MAX_FRAME_SIZE), le32(`UVC_FRAME_INTERVAL),
        8'h01, le32(`UVC_FRAME_INTERVAL)         // single discrete interval
    });
    localparam blob_t VS_ALT1 = blob_t'({
        8'h09, DT_INTERFACE, 8'h01, 8'h01, 8'h01, 8'h0E, 8'h02, 8'h00, 8'h00
    });
    localparam blob_t ISO_EP = blob_t'({
        8'h07, DT_ENDPOINT, DATA_EP, 8'h05,      // async iso
        le16({3'd0, `UVC_ADDITIONAL_PACKET, `UVC_PACKET_SIZE}), 8'h01
    });

    int ofs;

    assign ofs = int'(lk.offset);

    always_comb begin
        case (ofs) inside
            [0:8]:     lk.cfg_byte = byte_at(CFG_HDR, 9, ofs);
            [9:16]:    lk.cfg_byte = byte_at(IAD, 8, ofs - 9);
            [17:25]:   lk.cfg_byte = byte_at(VC_IF, 9, ofs - 17);
            [26:38]:   lk.cfg_byte = byte_at(VC_HDR, 13, ofs - 26);
            [39:56]:   lk.cfg_byte = byte_at(IN_TERM, 18, ofs - 39);
            [57:65]:   lk.cfg_byte = byte_at(OUT_TERM, 9, ofs - 57);
            [66:72]:   lk.cfg_byte = byte_at(INT_EP, 7, ofs - 66);
            [73:77]:   lk.cfg_byte = byte_at(CS_INT_EP, 5, ofs - 73);
            [78:86]:   lk.cfg_byte = byte_at(VS_ALT0, 9, ofs - 78);
            [87:100]:  lk.cfg_byte = byte_at(VS_IN_HDR, 14, ofs - 87);
            [101:127]: lk.cfg_byte = byte_at(FORMAT, 27, ofs - 101);
            [128:157]: lk.cfg_byte = byte_at(FRAME, 30, ofs - 128);
            [158:166]: lk.cfg_byte = byte_at(VS_ALT1, 9, ofs - 158);
            [167:173]: lk.cfg_byte = byte_at(ISO_EP, 7, ofs - 167);
            default:   lk.cfg_byte = '0;         // beyond CFG_LEN
        endcase
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/usb_desc_pkg.sv
logic/desc_lookup_if.sv
logic/desc_wb_slave.sv
logic/desc_addr_map.sv
logic/std_desc_rom.sv
logic/uvc_cfg_rom.sv
logic/string_desc_rom.sv
logic/usb_desc_top.sv
tb/desc_ref_pkg.sv
tb/tb_usb_desc.sv

// ==== tb/desc_ref_pkg.sv ====
package desc_ref_pkg;
    import usb_desc_pkg::*;
    `include "usb_desc_params.svh"

    // layout model; std table is padded up to the config descriptor
    localparam int REF_CFG_ADDR     = 32;
    localparam int REF_CFG_LEN      = 174;
    localparam int REF_LANG_ADDR    = REF_CFG_ADDR + REF_CFG_LEN;
    localparam int REF_VENDOR_ADDR  = REF_LANG_ADDR + 4;
    localparam int REF_VENDOR_LEN   = 2 + 2 * `USB_VENDOR_STR_LEN;
    localparam int REF_PRODUCT_ADDR = REF_VENDOR_ADDR + REF_VENDOR_LEN;
    localparam int REF_PRODUCT_LEN  = 2 + 2 * `USB_PRODUCT_STR_LEN;
    localparam int REF_END_ADDR     = REF_PRODUCT_ADDR + REF_PRODUCT_LEN;

    function automatic int kind_addr(input desc_kind_e kind);
        case (kind)
            KIND_DEVICE:    return 0;
            KIND_QUALIFIER: return 20;
            KIND_CONFIG:    return REF_CFG_ADDR;
            KIND_LANG:      return REF_LANG_ADDR;
            KIND_VENDOR:    return REF_VENDOR_ADDR;
            default:        return REF_PRODUCT_ADDR;
        endcase
    endfunction

    function automatic int kind_len(input desc_kind_e kind);
        case (kind)
            KIND_DEVICE:    return 18;
            KIND_QUALIFIER: return 10;
            KIND_CONFIG:    return REF_CFG_LEN;
            KIND_LANG:      return 4;
            KIND_VENDOR:    return REF_VENDOR_LEN;
            default:        return REF_PRODUCT_LEN;
        endcase
    endfunction

    // UTF-16LE string model, leftmost char first
    function automatic desc_byte_t string_byte(input string text, input int pos);
        if (pos == 0) begin
            return desc_byte_t'(2 + 2 * text.len());
        end else if (pos == 1) begin
            return 8'd3;                                  // STRING type
        end else if (pos % 2 == 1) begin
            return 8'h00;                                 // high byte of each char
        end
        return desc_byte_t'(text[(pos - 2) / 2]);
    endfunction

    function automatic desc_byte_t bm_attr();
        return {1'b1, `USB_SELF_POWERED, 6'd0};           // bit 7 always set
    endfunction

    function automatic bit allowed_type(input desc_byte_t t);
        return t inside {8'd2, 8'd4, 8'd5, 8'd11, 8'd36, 8'd37};
    endfunction

    // returns 0 where the rules leave the byte open
    function automatic bit expect_byte(input int adr, output desc_byte_t val);
        logic [15:0] bcd_usb;
        logic [15:0] vid;
        logic [15:0] pid;
        logic [15:0] ver;
        bcd_usb = `USB_HS_SUPPORT ? 16'h0200 : 16'h0110;
        vid     = `USB_VENDOR_ID;
        pid     = `USB_PRODUCT_ID;
        ver     = `USB_VERSION_BCD;
        val     = 8'h00;
        if (adr < 18) begin
            case (adr)
                0:  val = 8'd18;
                1:  val = 8'd1;
                2:  val = bcd_usb[7:0];
                3:  val = bcd_usb[15:8];
                4:  val = 8'hEF;                          // misc class
                5:  val = 8'h02;
                6:  val = 8'h01;                          // IAD protocol
                7:  return 1'b0;                          // ep0 size is open
                8:  val = vid[7:0];
                9:  val = vid[15:8];
                10: val = pid[7:0];
                11: val = pid[15:8];
                12: val = ver[7:0];
                13: val = ver[15:8];
                14: val = 8'd1;
                15: val = 8'd2;
                16: val = 8'd0;                           // no serial string
                default: val = 8'd1;                      // one configuration
            endcase
        end else if (adr < 20 || adr == 30 || adr == 31) begin
            val = 8'h00;                                  // padding
        end else if (adr == 20) begin
            val = 8'd10;
        end else if (adr == 21) begin
            val = 8'd6;
        end else if (adr < REF_CFG_ADDR) begin
            return 1'b0;
        end else if (adr < REF_LANG_ADDR) begin
            case (adr - REF_CFG_ADDR)
                0: val = 8'd9;
                1: val = 8'd2;
                2: val = desc_byte_t'(REF_CFG_LEN);       // wTotalLength low
                3: val = 8'd0;
                7: val = bm_attr();
                default: return 1'b0;                     // walked structurally instead
            endcase
        end else if (adr < REF_VENDOR_ADDR) begin
            case (adr - REF_LANG_ADDR)
                0: val = 8'd4;
                1: val = 8'd3;
                2: val = 8'h09;
                default: val = 8'h04;                     // en-US 0409
            endcase
        end else if (adr < REF_PRODUCT_ADDR) begin
            val = string_byte(`USB_VENDOR_STR, adr - REF_VENDOR_ADDR);
        end else if (adr < REF_END_ADDR) begin
            val = string_byte(`USB_PRODUCT_STR, adr - REF_PRODUCT_ADDR);
        end
        return 1'b1;
    endfunction

endpackage

// ==== tb/tb_usb_desc.sv ====
`timescale 1ns/1ps

module tb_usb_desc;
    import usb_desc_pkg::*;
    import desc_ref_pkg::*;

    localparam int N_RANDOM    = 3000;
    localparam int N_SWEEP     = REF_END_ADDR + 16;       // full image and a tail past it
    localparam int N_REQ       = N_RANDOM + N_SWEEP;
    localparam int WATCHDOG_NS = N_REQ * 6 * 8 + 2000;    // 6 cycles worst case per request

    logic       CLK;
    logic       RESET;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    desc_addr_t wb_adr;
    desc_byte_t wb_dat;
    logic       wb_ack;
    desc_kind_e desc_kind;
    desc_addr_t desc_addr;
    desc_len_t  desc_len;

    integer     seed;
    int         value_errors;
    int         rule_errors;
    desc_byte_t cfg_image [REF_CFG_LEN];                  // config bytes read back in sweep

    usb_desc_top u_dut (
        .CLK         (CLK),
        .RESET       (RESET),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .o_wb_dat    (wb_dat),
        .o_wb_ack    (wb_ack),
        .i_desc_kind (desc_kind),
        .o_desc_addr (desc_addr),
        .o_desc_len  (desc_len)
    );

    always #4 CLK = ~CLK;                                 // 8 ns period

    task automatic check_byte(input string name, input desc_byte_t exp, input desc_byte_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] t=%0t %s expected %02h actual %02h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input desc_addr_t exp, input desc_addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input desc_len_t exp, input desc_len_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        rule_errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic idle_wait(input int n);
        repeat (n) begin
            @(negedge CLK);
            if (wb_ack) note_failure("ack seen with no request pending");
        end
    endtask

    // one request from a falling edge, ack due one cycle later
    task automatic wb_transfer(input desc_addr_t adr, input logic we, output desc_byte_t dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        @(negedge CLK);
        if (!wb_ack) note_failure($sformatf("missing ack for address %0d", adr));
        dat    = wb_dat;
        @(negedge CLK);                                   // stb still held, ack must drop
        if (wb_ack) note_failure($sformatf("double ack for address %0d", adr));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input desc_addr_t adr, output desc_byte_t dat);
        desc_byte_t exp;
        wb_transfer(adr, 1'b0, dat);
        if (expect_byte(int'(adr), exp)) begin
            check_byte($sformatf("o_wb_dat at %0d", adr), exp, dat);
        end
    endtask

    // cyc raised without stb, then dropped while stb rises; no ack may follow
    task automatic abort_cycle(input desc_addr_t adr, input int hold);
        wb_cyc = 1'b1;
        wb_adr = adr;
        repeat (hold) begin
            @(negedge CLK);
            if (wb_ack) note_failure("ack during an aborted cycle");
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b1;                                    // stb alone is no request
        @(negedge CLK);
        if (wb_ack) note_failure("ack after an aborted cycle");
        wb_stb = 1'b0;
    endtask

    initial begin
        desc_byte_t dat;
        int         adr;
        int         pos;
        int         pick;
        seed         = 32'h64a1bb97;
        CLK          = 1'b0;
        RESET        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        desc_kind    = KIND_DEVICE;
        value_errors = 0;
        rule_errors  = 0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        if (wb_ack) note_failure("o_wb_ack high after reset");
        check_byte("o_wb_dat", 8'h00, wb_dat);
        RESET = 1'b0;

        for (int k = 0; k < 6; k++) begin                 // kind lookup, same cycle
            @(negedge CLK);
            desc_kind = desc_kind_e'(k);
            #1;
            check_addr("o_desc_addr", desc_addr_t'(kind_addr(desc_kind)), desc_addr);
            check_len("o_desc_len", desc_len_t'(kind_len(desc_kind)), desc_len);
        end
        @(negedge CLK);

        for (adr = 0; adr < N_SWEEP; adr++) begin         // ordered sweep of the image
            read_check(desc_addr_t'(adr), dat);
            if (adr >= REF_CFG_ADDR && adr < REF_LANG_ADDR) cfg_image[adr - REF_CFG_ADDR] = dat;
        end

        pos = 0;                                          // hop through config by bLength
        while (pos < REF_CFG_LEN && cfg_image[pos] != 8'd0) begin
            if (pos + 1 < REF_CFG_LEN && !allowed_type(cfg_image[pos + 1])) begin
                note_failure($sformatf("config offset %0d has disallowed type %0d",
                    pos, cfg_image[pos + 1]));
            end
            pos += int'(cfg_image[pos]);
        end
        if (pos != REF_CFG_LEN) begin
            note_failure($sformatf("config walk ended at %0d, not at %0d", pos, REF_CFG_LEN));
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            pick = int'($unsigned($random(seed)) % 16);
            if (pick < 12) adr = int'($unsigned($random(seed)) % N_SWEEP); // mostly in image
            else adr = int'($unsigned($random(seed)) % 1024);
            pick = int'($unsigned($random(seed)) % 16);
            if (pick == 0) begin
                abort_cycle(desc_addr_t'(adr), 1 + int'($unsigned($random(seed)) % 2));
            end else if (pick == 1) begin
                wb_transfer(desc_addr_t'(adr), 1'b1, dat);
                check_byte($sformatf("o_wb_dat on write to %0d", adr), 8'h00, dat);
            end else begin
                read_check(desc_addr_t'(adr), dat);
            end
            idle_wait(int'($unsigned($random(seed)) % 4));
        end

        $display("value errors: %0d, other errors: %0d", value_errors, rule_errors);
        if (value_errors + rule_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule
